// File: conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// frame size in pixels
`define CONV_IMG_W 7
`define CONV_IMG_H 7

// bits per pixel, unsigned
`define CONV_PIX_W 8

`endif

// File: conv_ctrl_pkg.sv
`include "conv_settings.svh"

package conv_ctrl_pkg;

  // line buffer frame control
  typedef enum logic [1:0] {
    IDLE,
    STREAM,
    FLUSH
  } frame_state_e;

  // row count runs two rows and two pixels past the frame during the flush
  typedef logic [$clog2(`CONV_IMG_H + 3)-1:0] row_cnt_t;

  typedef logic [$clog2(`CONV_IMG_W)-1:0] col_cnt_t;

endpackage

// File: conv_kernel_pkg.sv
`include "conv_settings.svh"

package conv_kernel_pkg;

  localparam int KTAPS = 25;

  // gauss centre weight is 36, so one bit more than 6
  localparam int COEF_W = 7;

  localparam int SHIFT_W = 4;

  typedef enum logic [1:0] {
    OP_PASS  = 2'd0,
    OP_BOX   = 2'd1,
    OP_GAUSS = 2'd2,
    OP_EDGE  = 2'd3
  } kernel_op_e;

  typedef logic signed [COEF_W-1:0] coef_t;

  typedef coef_t [KTAPS-1:0] coef_set_t;

  // index 0 is top-left, index 24 bottom-right, row major
  typedef logic [KTAPS-1:0][`CONV_PIX_W-1:0] window_t;

endpackage

// File: line_buffer.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module line_buffer
  import conv_ctrl_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`CONV_PIX_W-1:0]       i_pix,
  input  logic                         i_pix_valid,
  output logic                         o_pix_ready,
  output logic [4:0][`CONV_PIX_W-1:0]  o_col,
  output logic                         o_col_valid,
  input  logic                         i_col_ready,
  input  logic                         i_frame_done,
  output logic                         o_frame_start
);

  frame_state_e            state;
  row_cnt_t                row_cnt;
  col_cnt_t                col_cnt;
  logic                    flush_done;
  logic [`CONV_PIX_W-1:0]  row_mem [4][`CONV_IMG_W];
  logic                    slot_free;
  logic                    pix_take;
  logic                    flush_take;
  logic                    step;
  logic                    last_pix;
  logic                    last_step;
  logic [`CONV_PIX_W-1:0]  new_pix;

  assign slot_free     = !o_col_valid || i_col_ready;
  assign o_pix_ready   = (state != FLUSH) && slot_free;
  assign pix_take      = i_pix_valid && o_pix_ready;
  assign flush_take    = (state == FLUSH) && !flush_done && slot_free;
  assign step          = pix_take || flush_take;
  assign new_pix       = pix_take ? i_pix : '0;
  assign o_frame_start = pix_take && (state == IDLE);

  assign last_pix  = (row_cnt == row_cnt_t'(`CONV_IMG_H - 1)) &&
                     (col_cnt == col_cnt_t'(`CONV_IMG_W - 1));
  // centre of the last window reaches the middle two rows and two pixels later
  assign last_step = (row_cnt == row_cnt_t'(`CONV_IMG_H + 2)) &&
                     (col_cnt == col_cnt_t'(1));

  // column-wise shift of the four stored rows, oldest row at index 0
  always_ff @(posedge clk) begin
    if (step) begin
      for (int k = 0; k < 3; k++) begin
        row_mem[k][col_cnt] <= row_mem[k+1][col_cnt];
      end
      row_mem[3][col_cnt] <= new_pix;
      for (int k = 0; k < 4; k++) begin
        o_col[k] <= row_mem[k][col_cnt];
      end
      o_col[4] <= new_pix;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= IDLE;
      row_cnt     <= '0;
      col_cnt     <= '0;
      flush_done  <= 1'b0;
      o_col_valid <= 1'b0;
    end else begin
      if (slot_free) begin
        o_col_valid <= step;
      end
      if (step) begin
        if (col_cnt == col_cnt_t'(`CONV_IMG_W - 1)) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + row_cnt_t'(1);
        end else begin
          col_cnt <= col_cnt + col_cnt_t'(1);
        end
      end
      case (state)
        IDLE: begin
          if (pix_take) begin
            state <= STREAM;
          end
        end
        STREAM: begin
          if (pix_take && last_pix) begin
            state <= FLUSH;
          end
        end
        FLUSH: begin
          if (flush_take && last_step) begin
            flush_done <= 1'b1;
          end
          // wait for the last result to leave before taking a new frame
          if (i_frame_done) begin
            state      <= IDLE;
            row_cnt    <= '0;
            col_cnt    <= '0;
            flush_done <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: window_pad.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module window_pad
  import conv_ctrl_pkg::*;
  import conv_kernel_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [4:0][`CONV_PIX_W-1:0]  i_col,
  input  logic                         i_col_valid,
  output logic                         o_col_ready,
  output window_t                      o_win,
  output logic                         o_win_valid,
  input  logic                         i_win_ready,
  output logic                         o_win_last
);

  localparam int unsigned PRIME  = 2 * `CONV_IMG_W + 2;
  localparam int unsigned STEPS  = `CONV_IMG_W * `CONV_IMG_H + PRIME;
  localparam int unsigned STEP_W = $clog2(STEPS);

  window_t            shreg;
  logic [STEP_W-1:0]  step_cnt;
  row_cnt_t           ctr_row;
  col_cnt_t           ctr_col;
  logic               take;
  logic               primed;
  logic [4:0]         row_ok;
  logic [4:0]         col_ok;

  assign o_col_ready = !o_win_valid || i_win_ready;
  assign take        = i_col_valid && o_col_ready;
  assign primed      = step_cnt >= STEP_W'(PRIME);
  assign o_win_last  = (ctr_row == row_cnt_t'(`CONV_IMG_H - 1)) &&
                       (ctr_col == col_cnt_t'(`CONV_IMG_W - 1));

  // newest column enters on the right of each window row
  always_ff @(posedge clk) begin
    if (take) begin
      for (int k = 0; k < 5; k++) begin
        for (int j = 0; j < 4; j++) begin
          shreg[k*5+j] <= shreg[k*5+j+1];
        end
        shreg[k*5+4] <= i_col[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step_cnt    <= '0;
      ctr_row     <= '0;
      ctr_col     <= '0;
      o_win_valid <= 1'b0;
    end else begin
      if (o_col_ready) begin
        o_win_valid <= take && primed;
      end
      if (take) begin
        step_cnt <= (step_cnt == STEP_W'(STEPS - 1)) ? '0 : step_cnt + STEP_W'(1);
        // first full window is centred on pixel (0,0)
        if (step_cnt == STEP_W'(PRIME)) begin
          ctr_row <= '0;
          ctr_col <= '0;
        end else if (primed) begin
          if (ctr_col == col_cnt_t'(`CONV_IMG_W - 1)) begin
            ctr_col <= '0;
            ctr_row <= ctr_row + row_cnt_t'(1);
          end else begin
            ctr_col <= ctr_col + col_cnt_t'(1);
          end
        end
      end
    end
  end

  // tap row k sits at ctr_row + k - 2, tap column j at ctr_col + j - 2
  always_comb begin
    for (int k = 0; k < 5; k++) begin
      row_ok[k] = (int'(ctr_row) + k >= 2) && (int'(ctr_row) + k < `CONV_IMG_H + 2);
      col_ok[k] = (int'(ctr_col) + k >= 2) && (int'(ctr_col) + k < `CONV_IMG_W + 2);
    end
  end

  always_comb begin
    for (int k = 0; k < 5; k++) begin
      for (int j = 0; j < 5; j++) begin
        o_win[k*5+j] = (row_ok[k] && col_ok[j]) ? shreg[k*5+j] : '0;
      end
    end
  end

endmodule

// File: kernel_decode.sv
`timescale 1ns/1ps

module kernel_decode
  import conv_kernel_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  kernel_op_e          i_op,
  input  logic                i_op_load,
  output coef_set_t           o_coef,
  output logic [SHIFT_W-1:0]  o_shift
);

  localparam int KCENTER = KTAPS / 2;
  localparam int GAUSS_W [5] = '{1, 4, 6, 4, 1};

  kernel_op_e op_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_q <= OP_PASS;
    end else if (i_op_load) begin
      op_q <= i_op;
    end
  end

  always_comb begin
    o_coef  = '0;
    o_shift = '0;
    case (op_q)
      OP_PASS: begin
        o_coef[KCENTER] = coef_t'(1);
      end
      OP_BOX: begin
        for (int i = 0; i < KTAPS; i++) begin
          o_coef[i] = coef_t'(1);
        end
        o_shift = SHIFT_W'(5);
      end
      OP_GAUSS: begin
        // outer product of the binomial row and column weights
        for (int r = 0; r < 5; r++) begin
          for (int c = 0; c < 5; c++) begin
            o_coef[r*5+c] = coef_t'(GAUSS_W[r] * GAUSS_W[c]);
          end
        end
        o_shift = SHIFT_W'(8);
      end
      OP_EDGE: begin
        for (int i = 0; i < KTAPS; i++) begin
          o_coef[i] = coef_t'(-1);
        end
        o_coef[KCENTER] = coef_t'(24);
      end
      default: o_coef = '0;
    endcase
  end

endmodule

// File: conv_mac.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_mac
  import conv_kernel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  window_t                 i_win,
  input  logic                    i_win_valid,
  output logic                    o_win_ready,
  input  logic                    i_win_last,
  input  coef_set_t               i_coef,
  input  logic [SHIFT_W-1:0]      i_shift,
  output logic [`CONV_PIX_W-1:0]  o_pix,
  output logic                    o_pix_valid,
  input  logic                    i_pix_ready,
  output logic                    o_pix_last
);

  localparam int PROD_W  = `CONV_PIX_W + 1 + COEF_W;
  localparam int ACC_W   = PROD_W + $clog2(KTAPS);
  localparam int PIX_MAX = (1 << `CONV_PIX_W) - 1;

  logic signed [PROD_W-1:0]  prod_q [KTAPS];
  logic                      v1;
  logic                      last1;
  logic                      adv1;
  logic                      adv2;
  logic signed [ACC_W-1:0]   acc;
  logic signed [ACC_W-1:0]   shifted;
  logic [`CONV_PIX_W-1:0]    pix_d;

  assign adv2        = !o_pix_valid || i_pix_ready;
  assign adv1        = !v1 || adv2;
  assign o_win_ready = adv1;

  // stage one, pixels are unsigned so a zero bit goes on top
  always_ff @(posedge clk) begin
    if (adv1 && i_win_valid) begin
      for (int i = 0; i < KTAPS; i++) begin
        prod_q[i] <= $signed({1'b0, i_win[i]}) * $signed(i_coef[i]);
      end
      last1 <= i_win_last;
    end
  end

  always_comb begin
    acc = '0;
    for (int i = 0; i < KTAPS; i++) begin
      acc = acc + ACC_W'(prod_q[i]);
    end
    shifted = acc >>> i_shift;
    if (shifted < 0) begin
      pix_d = '0;
    end else if (shifted > PIX_MAX) begin
      pix_d = '1;
    end else begin
      pix_d = shifted[`CONV_PIX_W-1:0];
    end
  end

  // stage two
  always_ff @(posedge clk) begin
    if (adv2 && v1) begin
      o_pix      <= pix_d;
      o_pix_last <= last1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1          <= 1'b0;
      o_pix_valid <= 1'b0;
    end else begin
      if (adv1) begin
        v1 <= i_win_valid;
      end
      if (adv2) begin
        o_pix_valid <= v1;
      end
    end
  end

endmodule

// File: conv_result.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`CONV_PIX_W-1:0]  i_pix,
  input  logic                    i_pix_valid,
  output logic                    o_pix_ready,
  input  logic                    i_pix_last,
  output logic [`CONV_PIX_W-1:0]  o_res,
  output logic                    o_res_valid,
  input  logic                    i_res_ready,
  output logic                    o_res_last,
  output logic                    o_frame_done
);

  assign o_pix_ready  = !o_res_valid || i_res_ready;
  // last result of the frame leaves this cycle
  assign o_frame_done = o_res_valid && i_res_ready && o_res_last;

  always_ff @(posedge clk) begin
    if (o_pix_ready && i_pix_valid) begin
      o_res      <= i_pix;
      o_res_last <= i_pix_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_res_valid <= 1'b0;
    end else if (o_pix_ready) begin
      o_res_valid <= i_pix_valid;
    end
  end

endmodule

// File: conv_top.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_top
  import conv_kernel_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`CONV_PIX_W-1:0]  i_pix,
  input  kernel_op_e              i_op,
  input  logic                    i_pix_valid,
  output logic                    o_pix_ready,
  output logic [`CONV_PIX_W-1:0]  o_res,
  output logic                    o_res_last,
  output logic                    o_res_valid,
  input  logic                    i_res_ready
);

  logic [4:0][`CONV_PIX_W-1:0]  col_pix;
  logic                         col_valid;
  logic                         col_ready;
  logic                         frame_start;
  logic                         frame_done;
  window_t                      win;
  logic                         win_valid;
  logic                         win_ready;
  logic                         win_last;
  coef_set_t                    coef;
  logic [SHIFT_W-1:0]           shift;
  logic [`CONV_PIX_W-1:0]       mac_pix;
  logic                         mac_valid;
  logic                         mac_ready;
  logic                         mac_last;

  line_buffer u_line_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_pix         (i_pix),
    .i_pix_valid   (i_pix_valid),
    .o_pix_ready   (o_pix_ready),
    .o_col         (col_pix),
    .o_col_valid   (col_valid),
    .i_col_ready   (col_ready),
    .i_frame_done  (frame_done),
    .o_frame_start (frame_start)
  );

  window_pad u_window_pad (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col       (col_pix),
    .i_col_valid (col_valid),
    .o_col_ready (col_ready),
    .o_win       (win),
    .o_win_valid (win_valid),
    .i_win_ready (win_ready),
    .o_win_last  (win_last)
  );

  kernel_decode u_kernel_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_op      (i_op),
    .i_op_load (frame_start),
    .o_coef    (coef),
    .o_shift   (shift)
  );

  conv_mac u_conv_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_win       (win),
    .i_win_valid (win_valid),
    .o_win_ready (win_ready),
    .i_win_last  (win_last),
    .i_coef      (coef),
    .i_shift     (shift),
    .o_pix       (mac_pix),
    .o_pix_valid (mac_valid),
    .i_pix_ready (mac_ready),
    .o_pix_last  (mac_last)
  );

  conv_result u_conv_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_pix        (mac_pix),
    .i_pix_valid  (mac_valid),
    .o_pix_ready  (mac_ready),
    .i_pix_last   (mac_last),
    .o_res        (o_res),
    .o_res_valid  (o_res_valid),
    .i_res_ready  (i_res_ready),
    .o_res_last   (o_res_last),
    .o_frame_done (frame_done)
  );

endmodule

// File: conv_chk.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_chk (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_pix_valid,
  input  logic                    i_pix_ready,
  input  logic [`CONV_PIX_W-1:0]  i_res,
  input  logic                    i_res_valid,
  input  logic                    i_res_ready,
  input  logic                    i_res_last
);

  localparam int unsigned NPIX = `CONV_IMG_W * `CONV_IMG_H;

  int unsigned  in_cnt;
  logic         draining;
  int unsigned  fail_cnt = 0;

  // set once the frame's last input is taken, cleared when its last result leaves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_cnt   <= 0;
      draining <= 1'b0;
    end else begin
      if (i_pix_valid && i_pix_ready) begin
        if (in_cnt == NPIX - 1) begin
          in_cnt   <= 0;
          draining <= 1'b1;
        end else begin
          in_cnt <= in_cnt + 1;
        end
      end
      if (i_res_valid && i_res_ready && i_res_last) begin
        draining <= 1'b0;
      end
    end
  end

  a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_res_valid && !i_res_ready |=> i_res_valid && $stable(i_res) && $stable(i_res_last))
    else begin
      $error("result changed or dropped while the output was stalled");
      fail_cnt++;
    end

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !i_res_valid)
    else begin
      $error("result valid high right after reset");
      fail_cnt++;
    end

  a_drain_block: assert property (@(posedge clk) disable iff (!rst_n)
    draining |-> !i_pix_ready)
    else begin
      $error("input ready while the previous frame is still draining");
      fail_cnt++;
    end

endmodule

// File: tb_conv.sv
`timescale 1ns/1ps
`include "conv_settings.svh"

module tb_conv
  import conv_kernel_pkg::*;
();

  localparam int W              = `CONV_IMG_W;
  localparam int H              = `CONV_IMG_H;
  localparam int NPIX           = W * H;
  localparam int STEPS          = NPIX + 2 * W + 2;
  localparam int FRAMES         = 8;
  localparam int TIMEOUT_CYCLES = FRAMES * STEPS * 4 + 200;
  localparam logic [31:0] SEED  = 32'd96467;

  logic                    clk;
  logic                    rst_n;
  logic [`CONV_PIX_W-1:0]  i_pix;
  kernel_op_e              i_op;
  logic                    i_pix_valid;
  logic                    o_pix_ready;
  logic [`CONV_PIX_W-1:0]  o_res;
  logic                    o_res_last;
  logic                    o_res_valid;
  logic                    i_res_ready;

  logic [31:0]             st_in;
  logic [31:0]             st_out;
  logic [7:0]              img [NPIX];
  logic [7:0]              exp_q [$];
  int                      errors = 0;
  int                      res_cnt = 0;
  int                      cycle_cnt = 0;

  conv_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix       (i_pix),
    .i_op        (i_op),
    .i_pix_valid (i_pix_valid),
    .o_pix_ready (o_pix_ready),
    .o_res       (o_res),
    .o_res_last  (o_res_last),
    .o_res_valid (o_res_valid),
    .i_res_ready (i_res_ready)
  );

  bind conv_top conv_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_valid (i_pix_valid),
    .i_pix_ready (o_pix_ready),
    .i_res       (o_res),
    .i_res_valid (o_res_valid),
    .i_res_ready (i_res_ready),
    .i_res_last  (o_res_last)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // binomial weights 1 4 6 4 1
  function automatic int binom_weight(input int i);
    if (i == 0 || i == 4) return 1;
    else if (i == 1 || i == 3) return 4;
    else return 6;
  endfunction

  function automatic int tap_weight(input kernel_op_e op, input int kr, input int kc);
    case (op)
      OP_PASS:  return (kr == 2 && kc == 2) ? 1 : 0;
      OP_BOX:   return 1;
      OP_GAUSS: return binom_weight(kr) * binom_weight(kc);
      default:  return (kr == 2 && kc == 2) ? 24 : -1;
    endcase
  endfunction

  function automatic int tap_shift(input kernel_op_e op);
    case (op)
      OP_BOX:   return 5;
      OP_GAUSS: return 8;
      default:  return 0;
    endcase
  endfunction

  // zero padded 5x5 convolution of the stored frame at pixel (r, c)
  function automatic logic [7:0] model_pixel(input kernel_op_e op, input int r, input int c);
    int sum;
    int rr;
    int cc;
    sum = 0;
    for (int kr = 0; kr < 5; kr++) begin
      for (int kc = 0; kc < 5; kc++) begin
        rr = r + kr - 2;
        cc = c + kc - 2;
        if (rr >= 0 && rr < H && cc >= 0 && cc < W) begin
          sum = sum + tap_weight(op, kr, kc) * int'(img[rr * W + cc]);
        end
      end
    end
    sum = sum >>> tap_shift(op);
    if (sum < 0) return 8'd0;
    else if (sum > 255) return 8'd255;
    else return sum[7:0];
  endfunction

  task automatic send_frame(input kernel_op_e op);
    logic accepted;
    for (int p = 0; p < NPIX; p++) begin
      st_in = xorshift(st_in);
      // edge frames mix dark and bright pixels to reach both clamp limits
      if (op == OP_EDGE) img[p] = st_in[16] ? {4'hf, st_in[3:0]} : {4'h0, st_in[3:0]};
      else img[p] = st_in[15:8];
    end
    for (int p = 0; p < NPIX; p++) begin
      exp_q.push_back(model_pixel(op, p / W, p % W));
    end
    for (int p = 0; p < NPIX; p++) begin
      st_in = xorshift(st_in);
      while (st_in[1:0] == 2'b00) begin
        @(posedge clk);
        #2;
        st_in = xorshift(st_in);
      end
      i_pix = img[p];
      // opcode only matters with the first pixel
      i_op = (p == 0) ? op : kernel_op_e'(st_in[5:4]);
      i_pix_valid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = o_pix_ready;
        @(posedge clk);
        #2;
      end
      i_pix_valid = 1'b0;
    end
  endtask

  task automatic check_result();
    logic [7:0] exp_pix;
    logic       exp_last;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("result %02h arrived with no expected pixel left", o_res);
    end
    if (exp_q.size() != 0) begin
      exp_pix  = exp_q.pop_front();
      exp_last = (res_cnt % NPIX) == NPIX - 1;
      assert (o_res == exp_pix) else begin
        errors++;
        $display("ERROR: o_res frame %0d pixel %0d expected %02h actual %02h",
                 res_cnt / NPIX, res_cnt % NPIX, exp_pix, o_res);
      end
      assert (o_res_last == exp_last) else begin
        errors++;
        $display("ERROR: o_res_last frame %0d pixel %0d expected %0h actual %0h",
                 res_cnt / NPIX, res_cnt % NPIX, exp_last, o_res_last);
      end
      res_cnt++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // output side, random back-pressure and result checking
  initial begin : monitor
    i_res_ready = 1'b0;
    st_out = SEED ^ 32'h9e3779b9;
    forever begin
      @(posedge clk);
      #2;
      st_out = xorshift(st_out);
      i_res_ready = (st_out[1:0] != 2'b00);
      @(negedge clk);
      if (rst_n && o_res_valid && i_res_ready) begin
        check_result();
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d results still missing", cycle_cnt, exp_q.size());
    $display("Verification failed");
    $finish;
  end

  initial begin : stimulus
    kernel_op_e op;
    rst_n = 1'b0;
    i_pix = '0;
    i_op = OP_PASS;
    i_pix_valid = 1'b0;
    st_in = SEED;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int f = 0; f < FRAMES; f++) begin
      st_in = xorshift(st_in);
      case (f)
        0: op = OP_PASS;
        1: op = OP_GAUSS;
        2: op = OP_EDGE;
        3: op = OP_BOX;
        default: op = kernel_op_e'(st_in[9:8]);
      endcase
      send_frame(op);
    end
    while (exp_q.size() != 0) @(posedge clk);
    // catch any extra result
    repeat (20) @(posedge clk);
    assert (res_cnt == FRAMES * NPIX) else begin
      errors++;
      $display("wrong number of results, expected %0d and got %0d", FRAMES * NPIX, res_cnt);
    end
    $display("checked %0d results, %0d errors, %0d assertion failures",
             res_cnt, errors, uut.u_chk.fail_cnt);
    if (errors == 0 && uut.u_chk.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+.
conv_ctrl_pkg.sv
conv_kernel_pkg.sv
line_buffer.sv
window_pad.sv
kernel_decode.sv
conv_mac.sv
conv_result.sv
conv_top.sv
conv_chk.sv
tb_conv.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_conv -o tb_conv
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_conv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
